/* flist.f */
logic/aes_pkg.sv
logic/aes_sbox_word.sv
logic/aes_key_mem.sv
logic/aes_encipher.sv
logic/aes_core.sv
testbench/aes_checker.sv
testbench/aes_monitor.sv
testbench/aes_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AES testbench with Verilator
set -u

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module aes_tb \
    -f flist.f --Mdir "$BUILD_DIR" -o aes_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/aes_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1

/* testbench/aes_tb.sv */
`default_nettype none

module aes_tb;

    localparam int           CLK_PERIOD    = 100;
    localparam int           DRIVE_DELAY   = 10;
    localparam int           READY_TIMEOUT = 40;
    localparam int           DONE_TIMEOUT  = 40;
    localparam int           NUM_RANDOM    = 40;
    localparam logic [31:0]  LFSR_SEED     = 32'h63f0;
    localparam logic [31:0]  LFSR_TAPS     = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1
    localparam logic [127:0] KAT_KEY       = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] KAT_PT        = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] KAT_CT        = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic                clk_i;
    logic                round_ctr_rst;
    aes_pkg::key_cmd_t   key_cmd;
    aes_pkg::block_cmd_t block_cmd;
    logic                ready;
    logic                done;
    logic [127:0]        result;

    logic [31:0]         lfsr_state;
    int                  mon_errors;
    int                  mon_checked;
    int                  test_count;
    int                  failed_tests;
    int                  errors_at_start;
    int                  timeouts;

    aes_core uut (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .key_cmd_i     (key_cmd),
        .block_cmd_i   (block_cmd),
        .ready_o       (ready),
        .done_o        (done),
        .result_o      (result)
    );

    aes_monitor #(
        .KAT_KEY (KAT_KEY),
        .KAT_PT  (KAT_PT),
        .KAT_CT  (KAT_CT)
    ) u_monitor (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .key_cmd_i     (key_cmd),
        .block_cmd_i   (block_cmd),
        .ready_i       (ready),
        .done_i        (done),
        .result_i      (result),
        .error_count_o (mon_errors),
        .check_count_o (mon_checked)
    );

    bind aes_core aes_checker u_checker (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .init_i        (key_cmd_i.init),
        .next_i        (block_cmd_i.next),
        .ready_i       (ready_o),
        .done_i        (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic draw_128(output logic [127:0] v);
        for (int i = 0; i < 128; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[126:0], lfsr_state[0]};     // One step per bit
        end
    endtask

    function automatic int error_total();
        return mon_errors + timeouts + uut.u_checker.done_fails
               + uut.u_checker.next_fails + uut.u_checker.init_fails;
    endfunction

    task automatic tick();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic finish_run();
        $display("tests %0d, failed %0d, results checked %0d, errors %0d",
                 test_count, failed_tests, mon_checked, error_total());
        if (failed_tests == 0 && error_total() == 0 && mon_checked > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s within the allowed cycles", what);
        timeouts++;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < READY_TIMEOUT) begin
            tick();
            n++;
        end
        if (!ready) begin
            report_timeout("ready_o did not rise");
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < DONE_TIMEOUT) begin
            tick();
            n++;
        end
        if (!done) begin
            report_timeout("done_o did not pulse");
        end
    endtask

    task automatic load_key(input logic [127:0] k);
        key_cmd.init = 1'b1;
        key_cmd.key  = k;
        tick();
        key_cmd.init = 1'b0;
        wait_ready();
    endtask

    task automatic start_block(input logic [127:0] pt);
        block_cmd.next  = 1'b1;
        block_cmd.block = pt;
        tick();
        block_cmd.next = 1'b0;
    endtask

    task automatic run_block(input logic [127:0] pt);
        wait_ready();
        start_block(pt);
        wait_done();
    endtask

    task automatic begin_test();
        errors_at_start = error_total();
    endtask

    task automatic end_test(input string name);
        int errs;
        tick();
        tick();                                // Let the monitor see the last cycle
        errs = error_total() - errors_at_start;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", test_count, name, errs);
        end
    endtask

    initial begin
        logic [127:0] k;
        logic [127:0] pt;
        logic [127:0] pt2;
        lfsr_state    = LFSR_SEED;
        test_count    = 0;
        failed_tests  = 0;
        timeouts      = 0;
        round_ctr_rst = 1'b1;
        key_cmd       = '0;
        block_cmd     = '0;
        repeat (2) @(posedge clk_i);
        #DRIVE_DELAY;
        round_ctr_rst = 1'b0;

        begin_test();
        start_block(KAT_PT);                   // Ignored while no key is loaded
        repeat (20) tick();
        end_test("next before key load");

        begin_test();
        load_key(KAT_KEY);
        run_block(KAT_PT);
        end_test("known vector");

        begin_test();
        load_key(KAT_KEY);                     // Reload while ready
        run_block(KAT_PT);
        end_test("key load timing");

        begin_test();
        draw_128(pt);
        run_block(pt);
        repeat (15) tick();
        end_test("block timing and result hold");

        begin_test();
        draw_128(pt);
        draw_128(pt2);
        wait_ready();
        start_block(pt);
        repeat (3) tick();
        start_block(pt2);                      // Ignored while the cipher is busy
        wait_done();
        repeat (15) tick();
        end_test("next while busy");

        begin_test();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw_128(k);
            draw_128(pt);
            load_key(k);
            run_block(pt);
        end
        end_test("random traffic");

        begin_test();
        draw_128(k);
        load_key(k);
        for (int i = 0; i < 3; i++) begin
            draw_128(pt);
            run_block(pt);
        end
        draw_128(k);
        load_key(k);
        for (int i = 0; i < 3; i++) begin
            draw_128(pt);
            run_block(pt);
        end
        end_test("blocks under one key and reload");

        finish_run();
    end

endmodule

`default_nettype wire

/* testbench/aes_monitor.sv */
`default_nettype none

module aes_monitor #(
    parameter logic [127:0] KAT_KEY = '0,
    parameter logic [127:0] KAT_PT  = '0,
    parameter logic [127:0] KAT_CT  = '0
) (
    input  wire                        clk_i,
    input  wire                        round_ctr_rst,
    input  wire aes_pkg::key_cmd_t     key_cmd_i,
    input  wire aes_pkg::block_cmd_t   block_cmd_i,
    input  wire                        ready_i,
    input  wire                        done_i,
    input  wire [127:0]                result_i,
    output int                         error_count_o,
    output int                         check_count_o
);

    localparam int KEY_LATENCY   = 14;    // Init edge to key ready
    localparam int BLOCK_LATENCY = 10;    // Accepted next to done

    int           errors      = 0;
    int           checked     = 0;
    logic         kat_checked = 1'b0;
    logic [127:0] cur_key;
    logic [127:0] last_result;
    logic [127:0] expected;
    logic [127:0] expect_q [$];           // Results of blocks in flight
    int           key_cnt;
    int           enc_cnt;
    logic         key_ready_m;
    logic         ready_m;
    logic         done_m;

    assign error_count_o = errors;
    assign check_count_o = checked;

    function automatic logic [7:0] gf_double(input logic [7:0] b);
        logic [7:0] r;
        r = {b[6:0], 1'b0};
        if (b[7]) begin
            r = r ^ 8'h1b;                 // Reduce by the AES polynomial
        end
        return r;
    endfunction

    function automatic logic [7:0] gf_triple(input logic [7:0] b);
        return gf_double(b) ^ b;
    endfunction

    // AES-128 on a byte array, s[4*c + r] holds column c, row r
    function automatic logic [127:0] aes128_ref(input logic [127:0] key,
                                                input logic [127:0] pt);
        logic [31:0]         w [44];
        logic [7:0]          s [16];
        logic [7:0]          t [16];
        logic [7:0]          a [4];
        logic [31:0]         tmp;
        logic [7:0]          rc;
        aes_pkg::aes_block_u blk;
        for (int i = 0; i < 4; i++) begin
            w[i] = key[127 - 32*i -: 32];
        end
        rc = 8'h01;
        for (int i = 4; i < 44; i++) begin
            tmp = w[i-1];
            if (i % 4 == 0) begin
                tmp = {aes_pkg::SBOX[tmp[23:16]], aes_pkg::SBOX[tmp[15:8]],
                       aes_pkg::SBOX[tmp[7:0]], aes_pkg::SBOX[tmp[31:24]]};
                tmp[31:24] = tmp[31:24] ^ rc;
                rc = gf_double(rc);
            end
            w[i] = w[i-4] ^ tmp;
        end
        blk.flat = pt;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                s[4*c + r] = blk.col[c][r] ^ w[c][31 - 8*r -: 8];
            end
        end
        for (int rnd = 1; rnd <= 10; rnd++) begin
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    t[4*c + r] = aes_pkg::SBOX[s[4*((c + r) % 4) + r]];  // SubBytes, ShiftRows
                end
            end
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    a[r] = t[4*c + r];
                end
                if (rnd != 10) begin
                    t[4*c]     = gf_double(a[0]) ^ gf_triple(a[1]) ^ a[2] ^ a[3];
                    t[4*c + 1] = a[0] ^ gf_double(a[1]) ^ gf_triple(a[2]) ^ a[3];
                    t[4*c + 2] = a[0] ^ a[1] ^ gf_double(a[2]) ^ gf_triple(a[3]);
                    t[4*c + 3] = gf_triple(a[0]) ^ a[1] ^ a[2] ^ gf_double(a[3]);
                end
                for (int r = 0; r < 4; r++) begin
                    s[4*c + r] = t[4*c + r] ^ w[4*rnd + c][31 - 8*r -: 8];
                end
            end
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                blk.col[c][r] = s[4*c + r];
            end
        end
        return blk.flat;
    endfunction

    task automatic value_error(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
        errors++;
        $display("error: %s expected %0h got %0h at %0t", name, exp, got, $time);
    endtask

    task automatic event_error(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    // Outputs seen here belong to the cycle that this edge closes
    always @(posedge clk_i) begin
        if (!kat_checked) begin
            kat_checked = 1'b1;
            expected    = aes128_ref(KAT_KEY, KAT_PT);
            checked++;
            if (expected !== KAT_CT) begin
                value_error("reference ciphertext", KAT_CT, expected);
            end
        end
        if (round_ctr_rst) begin
            key_cnt     = 0;
            enc_cnt     = 0;
            key_ready_m = 1'b0;
            done_m      = 1'b0;
            last_result = '0;
            expect_q.delete();
        end else begin
            ready_m = key_ready_m && (enc_cnt == 0);
            if (ready_i !== ready_m) begin
                value_error("ready_o", {127'b0, ready_m}, {127'b0, ready_i});
            end
            if (done_i !== done_m) begin
                value_error("done_o", {127'b0, done_m}, {127'b0, done_i});
            end
            if (done_m && expect_q.size() > 0) begin
                expected = expect_q.pop_front();
                if (done_i) begin
                    checked++;
                    if (result_i !== expected) begin
                        value_error("result_o", expected, result_i);
                    end
                end
            end
            if (!done_i && result_i !== last_result) begin
                event_error("result_o changed while no block finished");
            end
            last_result = result_i;

            done_m = 1'b0;
            if (ready_m && block_cmd_i.next) begin
                expect_q.push_back(aes128_ref(cur_key, block_cmd_i.block));
                enc_cnt = BLOCK_LATENCY;
            end else if (enc_cnt > 0) begin
                enc_cnt--;
                done_m = (enc_cnt == 0);
            end
            if (key_cnt == 0 && key_cmd_i.init) begin
                cur_key     = key_cmd_i.key;   // Init is only taken when the key FSM is idle
                key_cnt     = KEY_LATENCY;
                key_ready_m = 1'b0;
            end else if (key_cnt > 0) begin
                key_cnt--;
                key_ready_m = (key_cnt == 0);
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/aes_checker.sv */
`default_nettype none

module aes_checker (
    input  wire clk_i,
    input  wire round_ctr_rst,
    input  wire init_i,
    input  wire next_i,
    input  wire ready_i,
    input  wire done_i
);

    int done_fails = 0;    // Failed assertion counts
    int next_fails = 0;
    int init_fails = 0;

    a_done_single: assert property (@(posedge clk_i) disable iff (round_ctr_rst)
        done_i |=> !done_i)
        else begin
            $error("done_o stayed high for two cycles");
            done_fails++;
        end

    // An accepted block start makes the cipher busy
    a_next_busy: assert property (@(posedge clk_i) disable iff (round_ctr_rst)
        (next_i && ready_i) |=> !ready_i)
        else begin
            $error("ready_o stayed high after an accepted next");
            next_fails++;
        end

    a_init_busy: assert property (@(posedge clk_i) disable iff (round_ctr_rst)
        (init_i && ready_i) |=> !ready_i)
        else begin
            $error("ready_o stayed high after an accepted init");
            init_fails++;
        end

endmodule

`default_nettype wire

/* logic/aes_core.sv */
`default_nettype none

module aes_core (
    input  wire                        clk_i,
    input  wire                        round_ctr_rst,
    input  wire aes_pkg::key_cmd_t     key_cmd_i,
    input  wire aes_pkg::block_cmd_t   block_cmd_i,
    output logic                       ready_o,
    output logic                       done_o,
    output logic [127:0]               result_o
);

    logic [31:0]    sbox_req;      // Key schedule word to substitute
    logic [31:0]    sbox_resp;
    logic [3:0]     round_idx;     // Round requested by the cipher
    logic [127:0]   round_key;
    logic           key_ready;

    aes_key_mem u_key_mem (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .key_cmd_i     (key_cmd_i),
        .round_i       (round_idx),
        .round_key_o   (round_key),
        .ready_o       (key_ready),
        .sbox_o        (sbox_req),
        .sbox_i        (sbox_resp)
    );

    // Shared S-box serving the key schedule
    aes_sbox_word u_sbox_word (
        .word_i (sbox_req),
        .word_o (sbox_resp)
    );

    aes_encipher u_encipher (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .block_cmd_i   (block_cmd_i),
        .key_ready_i   (key_ready),
        .round_o       (round_idx),
        .round_key_i   (round_key),
        .ready_o       (ready_o),
        .done_o        (done_o),
        .result_o      (result_o)
    );

endmodule

`default_nettype wire

/* logic/aes_encipher.sv */
`default_nettype none

module aes_encipher (
    input  wire                        clk_i,
    input  wire                        round_ctr_rst,
    input  wire aes_pkg::block_cmd_t   block_cmd_i,
    input  wire                        key_ready_i,
    output logic [3:0]                 round_o,
    input  wire [127:0]                round_key_i,
    output logic                       ready_o,
    output logic                       done_o,
    output logic [127:0]               result_o
);

    typedef enum logic {
        ENC_IDLE,
        ENC_BUSY
    } enc_state_e;

    enc_state_e           state_reg;
    logic [3:0]           round_ctr_reg;
    logic                 start;
    logic                 last_round;

    aes_pkg::aes_block_u  block_reg;
    aes_pkg::aes_block_u  sub_blk;
    aes_pkg::aes_block_u  shift_blk;
    aes_pkg::aes_block_u  mix_blk;
    aes_pkg::aes_block_u  round_blk;

    function automatic logic [0:3][7:0] mix_column(input logic [0:3][7:0] a);
        logic [0:3][7:0] b;
        b[0] = aes_pkg::xtime(a[0]) ^ aes_pkg::xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        b[1] = a[0] ^ aes_pkg::xtime(a[1]) ^ aes_pkg::xtime(a[2]) ^ a[2] ^ a[3];
        b[2] = a[0] ^ a[1] ^ aes_pkg::xtime(a[2]) ^ aes_pkg::xtime(a[3]) ^ a[3];
        b[3] = aes_pkg::xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ aes_pkg::xtime(a[3]);
        return b;
    endfunction

    assign ready_o    = key_ready_i && (state_reg == ENC_IDLE);
    assign start      = ready_o && block_cmd_i.next;
    assign last_round = (round_ctr_reg == 4'(aes_pkg::NUM_ROUNDS));
    assign round_o    = (state_reg == ENC_IDLE) ? 4'd0 : round_ctr_reg;   // Key 0 while idle

    // One full cipher round on the current state
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                sub_blk.col[c][r] = aes_pkg::SBOX[block_reg.col[c][r]];
            end
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_blk.col[c][r] = sub_blk.col[(c + r) % 4][r];   // Row r rotates left by r
            end
        end
        for (int c = 0; c < 4; c++) begin
            mix_blk.col[c] = mix_column(shift_blk.col[c]);
        end
        if (last_round) begin
            round_blk.flat = shift_blk.flat ^ round_key_i;   // No MixColumns in round 10
        end else begin
            round_blk.flat = mix_blk.flat ^ round_key_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (round_ctr_rst) begin
            state_reg     <= ENC_IDLE;
            round_ctr_reg <= 4'd0;
            done_o        <= 1'b0;
            result_o      <= '0;
        end else begin
            done_o <= 1'b0;
            case (state_reg)
                ENC_IDLE: begin
                    if (start) begin
                        state_reg     <= ENC_BUSY;
                        round_ctr_reg <= 4'd1;
                    end
                end
                ENC_BUSY: begin
                    if (last_round) begin
                        state_reg <= ENC_IDLE;
                        done_o    <= 1'b1;           // Single cycle pulse
                        result_o  <= round_blk.flat;
                    end else begin
                        round_ctr_reg <= round_ctr_reg + 4'd1;
                    end
                end
                default: state_reg <= ENC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            block_reg.flat <= block_cmd_i.block ^ round_key_i;   // Initial AddRoundKey
        end else if (state_reg == ENC_BUSY) begin
            block_reg <= round_blk;
        end
    end

endmodule

`default_nettype wire

/* logic/aes_key_mem.sv */
`default_nettype none

module aes_key_mem (
    input  wire                      clk_i,
    input  wire                      round_ctr_rst,
    input  wire aes_pkg::key_cmd_t   key_cmd_i,
    input  wire [3:0]                round_i,
    output logic [127:0]             round_key_o,
    output logic                     ready_o,
    output logic [31:0]              sbox_o,
    input  wire [31:0]               sbox_i
);

    typedef enum logic [1:0] {
        KEY_IDLE,
        KEY_INIT,
        KEY_GENERATE,
        KEY_DONE
    } key_state_e;

    key_state_e     state_reg;
    key_state_e     state_new;

    logic [127:0]   key_mem [0:aes_pkg::NUM_ROUNDS];
    logic [127:0]   prev_key_reg;
    logic [127:0]   key_new;
    logic           key_we;
    logic           key_latch;

    logic [3:0]     round_ctr_reg;
    logic           round_ctr_clr;
    logic           round_ctr_inc;

    logic [7:0]     rcon_reg;
    logic [7:0]     rcon_new;
    logic           rcon_set;
    logic           rcon_next;

    logic           ready_reg;
    logic           ready_set;
    logic           ready_clr;

    logic [31:0]    w0, w1, w2, w3;
    logic [31:0]    k0, k1, k2, k3;
    logic [31:0]    trw;

    assign round_key_o = key_mem[round_i];     // Combinational read port
    assign ready_o     = ready_reg;
    assign sbox_o      = prev_key_reg[31:0];   // Last word of the previous key
    assign rcon_new    = aes_pkg::xtime(rcon_reg);

    // Next round key from the previous one
    always_comb begin
        w0  = prev_key_reg[127:96];
        w1  = prev_key_reg[95:64];
        w2  = prev_key_reg[63:32];
        w3  = prev_key_reg[31:0];
        trw = {sbox_i[23:0], sbox_i[31:24]} ^ {rcon_reg, 24'h0};   // RotWord after SubWord
        k0  = w0 ^ trw;
        k1  = w1 ^ k0;
        k2  = w2 ^ k1;
        k3  = w3 ^ k2;
        if (round_ctr_reg == 4'd0) begin
            key_new = prev_key_reg;    // Round 0 is the cipher key itself
        end else begin
            key_new = {k0, k1, k2, k3};
        end
    end

    always_comb begin
        state_new     = state_reg;
        key_we        = 1'b0;
        key_latch     = 1'b0;
        round_ctr_clr = 1'b0;
        round_ctr_inc = 1'b0;
        rcon_set      = 1'b0;
        rcon_next     = 1'b0;
        ready_set     = 1'b0;
        ready_clr     = 1'b0;
        case (state_reg)
            KEY_IDLE: begin
                if (key_cmd_i.init) begin
                    key_latch = 1'b1;
                    ready_clr = 1'b1;
                    state_new = KEY_INIT;
                end
            end
            KEY_INIT: begin
                round_ctr_clr = 1'b1;
                rcon_set      = 1'b1;
                state_new     = KEY_GENERATE;
            end
            KEY_GENERATE: begin
                if (round_ctr_reg == 4'(aes_pkg::NUM_ROUNDS + 1)) begin
                    state_new = KEY_DONE;      // All eleven keys written
                end else begin
                    key_we        = 1'b1;
                    rcon_next     = 1'b1;
                    round_ctr_inc = 1'b1;
                end
            end
            KEY_DONE: begin
                ready_set = 1'b1;
                state_new = KEY_IDLE;
            end
            default: state_new = KEY_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (round_ctr_rst) begin
            state_reg     <= KEY_IDLE;
            round_ctr_reg <= 4'd0;
            rcon_reg      <= 8'h8d;
            ready_reg     <= 1'b0;
            for (int i = 0; i <= aes_pkg::NUM_ROUNDS; i++) begin
                key_mem[i] <= '0;
            end
        end else begin
            state_reg <= state_new;
            if (round_ctr_clr) begin
                round_ctr_reg <= 4'd0;
            end else if (round_ctr_inc) begin
                round_ctr_reg <= round_ctr_reg + 4'd1;
            end
            if (rcon_set) begin
                rcon_reg <= 8'h8d;             // One step before 01
            end else if (rcon_next) begin
                rcon_reg <= rcon_new;
            end
            if (ready_clr) begin
                ready_reg <= 1'b0;
            end else if (ready_set) begin
                ready_reg <= 1'b1;
            end
            if (key_we) begin
                key_mem[round_ctr_reg] <= key_new;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (key_latch) begin
            prev_key_reg <= key_cmd_i.key;     // Capture key with the command
        end else if (key_we) begin
            prev_key_reg <= key_new;
        end
    end

endmodule

`default_nettype wire

/* logic/aes_sbox_word.sv */
`default_nettype none

// Four parallel S-box lookups for the key schedule
module aes_sbox_word (
    input  wire [31:0]  word_i,
    output logic [31:0] word_o
);

    logic [7:0] byte_in  [4];
    logic [7:0] byte_out [4];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byte_in[i]  = word_i[8*i +: 8];           // Split into bytes
            byte_out[i] = aes_pkg::SBOX[byte_in[i]];  // Table lookup
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            word_o[8*i +: 8] = byte_out[i];           // Reassemble word
        end
    end

endmodule

`default_nettype wire

/* logic/aes_pkg.sv */
`default_nettype none

package aes_pkg;

    localparam int NUM_ROUNDS = 10;    // AES-128 round count

    // Forward S-box, indexed by the input byte
    localparam logic [7:0] SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
    endfunction

    typedef struct packed {
        logic         init;     // Key load strobe
        logic [127:0] key;      // Cipher key
    } key_cmd_t;

    typedef struct packed {
        logic         next;     // Block start strobe
        logic [127:0] block;    // Plaintext
    } block_cmd_t;

    // Column c, row r sits at col[c][r], byte 0 in the top bits
    typedef union packed {
        logic [127:0]          flat;
        logic [0:3][0:3][7:0]  col;
    } aes_block_u;

endpackage

`default_nettype wire
